//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_snoop_cache
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Regression passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST) $(wildcard *.sv)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- cd_beat_sender.sv
`default_nettype none

module cd_beat_sender (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          load_i,
  input  logic [snoop_pkg::LINE_W-1:0]  line_i,
  output logic                          cd_valid_o,
  output logic [snoop_pkg::BEAT_W-1:0]  cd_data_o,
  output logic                          cd_last_o,
  input  logic                          cd_ready_i,
  output logic                          done_o
);
  import snoop_pkg::*;

  logic [LINE_W-1:0] line_q;
  logic              beat_q;
  logic              valid_q;

  // lower half goes first
  assign cd_valid_o = valid_q;
  assign cd_data_o  = beat_q ? line_q[LINE_W-1 -: BEAT_W] : line_q[BEAT_W-1:0];
  assign cd_last_o  = beat_q;
  assign done_o     = valid_q && cd_ready_i && beat_q;

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      line_q <= line_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      beat_q  <= 1'b0;
    end else if (load_i) begin
      valid_q <= 1'b1;
      beat_q  <= 1'b0;
    end else if (valid_q && cd_ready_i) begin
      valid_q <= !beat_q;
      beat_q  <= !beat_q;
    end
  end

endmodule

`default_nettype wire

//--- line_data_array.sv
`default_nettype none

module line_data_array #(
  parameter int unsigned WAYS    = 4,
  parameter int unsigned INDEX_W = 4,
  localparam int unsigned WAY_W  = (WAYS > 1) ? $clog2(WAYS) : 1
) (
  input  logic                          clk_i,
  input  logic                          fill_valid_i,
  input  logic [snoop_pkg::ADDR_W-1:0]  fill_addr_i,
  input  logic [WAY_W-1:0]              fill_way_i,
  input  logic [snoop_pkg::LINE_W-1:0]  fill_data_i,
  input  logic                          lookup_gnt_i,
  input  logic [INDEX_W-1:0]            lookup_index_i,
  input  logic [WAYS-1:0]               hit_way_i,
  output logic [snoop_pkg::LINE_W-1:0]  line_o
);
  import snoop_pkg::*;

  localparam int unsigned SETS = 1 << INDEX_W;

  logic [LINE_W-1:0]  data_mem [SETS][WAYS];
  logic [LINE_W-1:0]  rd_q     [WAYS];
  logic [INDEX_W-1:0] fill_index;

  assign fill_index = fill_addr_i[OFFSET_W +: INDEX_W];

  always_ff @(posedge clk_i) begin
    if (fill_valid_i) begin
      data_mem[fill_index][fill_way_i] <= fill_data_i;
    end
  end

  // whole set read, way picked when the hit vector shows up
  always_ff @(posedge clk_i) begin
    if (lookup_gnt_i) begin
      for (int w = 0; w < WAYS; w++) begin
        rd_q[w] <= data_mem[lookup_index_i][w];
      end
    end
  end

  always_comb begin
    line_o = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (hit_way_i[w]) begin
        line_o = rd_q[w];
      end
    end
  end

endmodule

`default_nettype wire

//--- project.f
snoop_pkg.sv
snoop_ctrl.sv
tag_state_array.sv
line_data_array.sv
cd_beat_sender.sv
snoop_cache_top.sv
tb_snoop_cache.sv

//--- snoop_cache_top.sv
`default_nettype none

module snoop_cache_top #(
  parameter int unsigned WAYS    = 4,
  parameter int unsigned INDEX_W = 4,
  localparam int unsigned TAG_W  = snoop_pkg::ADDR_W - INDEX_W - snoop_pkg::OFFSET_W,
  localparam int unsigned WAY_W  = (WAYS > 1) ? $clog2(WAYS) : 1
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          bypass_i,
  // AC channel
  input  logic                          ac_valid_i,
  input  logic [snoop_pkg::ADDR_W-1:0]  ac_addr_i,
  input  snoop_pkg::snoop_e             ac_snoop_i,
  output logic                          ac_ready_o,
  // CR channel
  output logic                          cr_valid_o,
  output snoop_pkg::cr_resp_t           cr_resp_o,
  input  logic                          cr_ready_i,
  // CD channel
  output logic                          cd_valid_o,
  output logic [snoop_pkg::BEAT_W-1:0]  cd_data_o,
  output logic                          cd_last_o,
  input  logic                          cd_ready_i,
  // fill port
  input  logic                          fill_valid_i,
  input  logic [snoop_pkg::ADDR_W-1:0]  fill_addr_i,
  input  logic [WAY_W-1:0]              fill_way_i,
  input  logic [snoop_pkg::LINE_W-1:0]  fill_data_i,
  input  logic                          fill_dirty_i,
  input  logic                          fill_shared_i,
  // status
  output logic                          busy_o,
  output logic                          invalidate_o,
  output logic [snoop_pkg::ADDR_W-1:0]  invalidate_addr_o
);
  import snoop_pkg::*;

  logic               lookup_req;
  logic [INDEX_W-1:0] lookup_index;
  logic [TAG_W-1:0]   lookup_tag;
  logic               lookup_gnt;
  logic [WAYS-1:0]    hit_way;
  logic               hit_dirty;
  logic               hit_shared;
  logic               flag_we;
  logic [WAYS-1:0]    flag_way;
  line_state_u        flag_mask;
  line_state_u        flag_value;
  logic [LINE_W-1:0]  line_data;
  logic               cd_load;
  logic               cd_done;

  snoop_ctrl #(
    .WAYS    (WAYS),
    .INDEX_W (INDEX_W)
  ) u_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .bypass_i          (bypass_i),
    .ac_valid_i        (ac_valid_i),
    .ac_addr_i         (ac_addr_i),
    .ac_snoop_i        (ac_snoop_i),
    .ac_ready_o        (ac_ready_o),
    .lookup_req_o      (lookup_req),
    .lookup_index_o    (lookup_index),
    .lookup_tag_o      (lookup_tag),
    .lookup_gnt_i      (lookup_gnt),
    .hit_way_i         (hit_way),
    .hit_dirty_i       (hit_dirty),
    .hit_shared_i      (hit_shared),
    .flag_we_o         (flag_we),
    .flag_way_o        (flag_way),
    .flag_mask_o       (flag_mask),
    .flag_value_o      (flag_value),
    .cr_valid_o        (cr_valid_o),
    .cr_resp_o         (cr_resp_o),
    .cr_ready_i        (cr_ready_i),
    .cd_load_o         (cd_load),
    .cd_done_i         (cd_done),
    .invalidate_o      (invalidate_o),
    .invalidate_addr_o (invalidate_addr_o),
    .busy_o            (busy_o)
  );

  tag_state_array #(
    .WAYS    (WAYS),
    .INDEX_W (INDEX_W)
  ) u_tags (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fill_valid_i   (fill_valid_i),
    .fill_addr_i    (fill_addr_i),
    .fill_way_i     (fill_way_i),
    .fill_dirty_i   (fill_dirty_i),
    .fill_shared_i  (fill_shared_i),
    .lookup_req_i   (lookup_req),
    .lookup_index_i (lookup_index),
    .lookup_tag_i   (lookup_tag),
    .lookup_gnt_o   (lookup_gnt),
    .hit_way_o      (hit_way),
    .hit_dirty_o    (hit_dirty),
    .hit_shared_o   (hit_shared),
    .flag_we_i      (flag_we),
    .flag_way_i     (flag_way),
    .flag_mask_i    (flag_mask),
    .flag_value_i   (flag_value)
  );

  line_data_array #(
    .WAYS    (WAYS),
    .INDEX_W (INDEX_W)
  ) u_data (
    .clk_i          (clk_i),
    .fill_valid_i   (fill_valid_i),
    .fill_addr_i    (fill_addr_i),
    .fill_way_i     (fill_way_i),
    .fill_data_i    (fill_data_i),
    .lookup_gnt_i   (lookup_gnt),
    .lookup_index_i (lookup_index),
    .hit_way_i      (hit_way),
    .line_o         (line_data)
  );

  cd_beat_sender u_cd (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .load_i     (cd_load),
    .line_i     (line_data),
    .cd_valid_o (cd_valid_o),
    .cd_data_o  (cd_data_o),
    .cd_last_o  (cd_last_o),
    .cd_ready_i (cd_ready_i),
    .done_o     (cd_done)
  );

endmodule

`default_nettype wire

//--- snoop_ctrl.sv
`default_nettype none

module snoop_ctrl #(
  parameter int unsigned WAYS    = 4,
  parameter int unsigned INDEX_W = 4,
  localparam int unsigned TAG_W  = snoop_pkg::ADDR_W - INDEX_W - snoop_pkg::OFFSET_W
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          bypass_i,
  // AC channel
  input  logic                          ac_valid_i,
  input  logic [snoop_pkg::ADDR_W-1:0]  ac_addr_i,
  input  snoop_pkg::snoop_e             ac_snoop_i,
  output logic                          ac_ready_o,
  // array lookup
  output logic                          lookup_req_o,
  output logic [INDEX_W-1:0]            lookup_index_o,
  output logic [TAG_W-1:0]              lookup_tag_o,
  input  logic                          lookup_gnt_i,
  input  logic [WAYS-1:0]               hit_way_i,
  input  logic                          hit_dirty_i,
  input  logic                          hit_shared_i,
  // state write
  output logic                          flag_we_o,
  output logic [WAYS-1:0]               flag_way_o,
  output snoop_pkg::line_state_u        flag_mask_o,
  output snoop_pkg::line_state_u        flag_value_o,
  // CR channel
  output logic                          cr_valid_o,
  output snoop_pkg::cr_resp_t           cr_resp_o,
  input  logic                          cr_ready_i,
  // CD sender
  output logic                          cd_load_o,
  input  logic                          cd_done_i,
  // status
  output logic                          invalidate_o,
  output logic [snoop_pkg::ADDR_W-1:0]  invalidate_addr_o,
  output logic                          busy_o
);
  import snoop_pkg::*;

  localparam logic [2:0] ST_IDLE   = 3'd0;
  localparam logic [2:0] ST_LOOKUP = 3'd1;
  localparam logic [2:0] ST_EVAL   = 3'd2;
  localparam logic [2:0] ST_SHARED = 3'd3;
  localparam logic [2:0] ST_INVAL  = 3'd4;
  localparam logic [2:0] ST_CR     = 3'd5;
  localparam logic [2:0] ST_CD     = 3'd6;

  logic [2:0]         state_q, state_d;
  cr_resp_t           resp_q, resp_d;
  logic [WAYS-1:0]    way_q, way_d;
  logic [INDEX_W-1:0] index_q;
  logic [TAG_W-1:0]   tag_q;
  snoop_e             snoop_q;
  logic               snoop_known;

  assign snoop_known = ac_snoop_i inside {READ_ONCE, READ_SHARED, READ_UNIQUE, CLEAN_INVALID};

  assign busy_o            = (state_q != ST_IDLE);
  assign lookup_index_o    = index_q;
  assign lookup_tag_o      = tag_q;
  assign flag_way_o        = way_q;
  assign cr_resp_o         = resp_q;
  assign invalidate_addr_o = {tag_q, index_q, {OFFSET_W{1'b0}}};

  always_comb begin
    state_d      = state_q;
    resp_d       = resp_q;
    way_d        = way_q;
    ac_ready_o   = 1'b0;
    lookup_req_o = 1'b0;
    flag_we_o    = 1'b0;
    flag_mask_o  = '0;
    flag_value_o = '0;
    cr_valid_o   = 1'b0;
    cd_load_o    = 1'b0;
    invalidate_o = 1'b0;

    case (state_q)
      ST_IDLE: begin
        if (ac_valid_i) begin
          ac_ready_o = 1'b1;
          resp_d     = '0;
          if (bypass_i) begin
            state_d = ST_CR;
          end else if (snoop_known) begin
            state_d = ST_LOOKUP;
          end else begin
            resp_d.error = 1'b1;
            state_d      = ST_CR;
          end
        end
      end

      ST_LOOKUP: begin
        // fills win the arrays, so this may take a while
        lookup_req_o = 1'b1;
        if (lookup_gnt_i) begin
          state_d = ST_EVAL;
        end
      end

      ST_EVAL: begin
        way_d = hit_way_i;
        if (|hit_way_i) begin
          case (snoop_q)
            READ_ONCE: begin
              resp_d.dataTransfer = 1'b1;
              resp_d.isShared     = hit_shared_i;
              state_d             = ST_CR;
            end
            READ_SHARED: begin
              resp_d.dataTransfer = 1'b1;
              resp_d.isShared     = 1'b1;
              state_d             = ST_SHARED;
            end
            READ_UNIQUE: begin
              resp_d.dataTransfer = 1'b1;
              resp_d.passDirty    = hit_dirty_i;
              state_d             = ST_INVAL;
            end
            default: begin
              // clean invalid, data only when dirty
              resp_d.dataTransfer = hit_dirty_i;
              resp_d.passDirty    = hit_dirty_i;
              state_d             = ST_INVAL;
            end
          endcase
        end else begin
          // miss keeps the all-zero response
          state_d = ST_CR;
        end
      end

      ST_SHARED: begin
        flag_we_o                 = 1'b1;
        // shared is the lowest bit of the state word
        flag_mask_o.bits          = 3'b001;
        flag_value_o.flags.shared = 1'b1;
        if (lookup_gnt_i) begin
          state_d = ST_CR;
        end
      end

      ST_INVAL: begin
        flag_we_o        = 1'b1;
        flag_mask_o.bits = '1;
        flag_value_o     = '0;
        if (lookup_gnt_i) begin
          invalidate_o = 1'b1;
          state_d      = ST_CR;
        end
      end

      ST_CR: begin
        cr_valid_o = 1'b1;
        if (cr_ready_i) begin
          if (resp_q.dataTransfer) begin
            cd_load_o = 1'b1;
            state_d   = ST_CD;
          end else begin
            state_d = ST_IDLE;
          end
        end
      end

      ST_CD: begin
        if (cd_done_i) begin
          state_d = ST_IDLE;
        end
      end

      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      resp_q  <= '0;
      way_q   <= '0;
    end else begin
      state_q <= state_d;
      resp_q  <= resp_d;
      way_q   <= way_d;
    end
  end

  // request details, taken on acceptance
  always_ff @(posedge clk_i) begin
    if (ac_ready_o) begin
      index_q <= ac_addr_i[OFFSET_W +: INDEX_W];
      tag_q   <= ac_addr_i[ADDR_W-1 -: TAG_W];
      snoop_q <= ac_snoop_i;
    end
  end

endmodule

`default_nettype wire

//--- snoop_pkg.sv
`default_nettype none

package snoop_pkg;

  // bus and line geometry
  localparam int unsigned ADDR_W   = 32;
  localparam int unsigned LINE_W   = 128;
  localparam int unsigned BEAT_W   = 64;
  localparam int unsigned OFFSET_W = 4;

  // AC snoop types served by the cache, anything else is an error
  typedef enum logic [3:0] {
    READ_ONCE     = 4'd0,
    READ_SHARED   = 4'd1,
    READ_UNIQUE   = 4'd7,
    CLEAN_INVALID = 4'd9
  } snoop_e;

  // CR response bits, msb first
  typedef struct packed {
    logic dataTransfer;
    logic passDirty;
    logic isShared;
    logic error;
  } cr_resp_t;

  // per-line state flags
  typedef struct packed {
    logic valid;
    logic dirty;
    logic shared;
  } line_flags_t;

  // same word seen as named flags or as a raw vector for masking
  typedef union packed {
    line_flags_t flags;
    logic [2:0]  bits;
  } line_state_u;

endpackage

`default_nettype wire

//--- tag_state_array.sv
`default_nettype none

module tag_state_array #(
  parameter int unsigned WAYS    = 4,
  parameter int unsigned INDEX_W = 4,
  localparam int unsigned TAG_W  = snoop_pkg::ADDR_W - INDEX_W - snoop_pkg::OFFSET_W,
  localparam int unsigned WAY_W  = (WAYS > 1) ? $clog2(WAYS) : 1
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // fill port
  input  logic                          fill_valid_i,
  input  logic [snoop_pkg::ADDR_W-1:0]  fill_addr_i,
  input  logic [WAY_W-1:0]              fill_way_i,
  input  logic                          fill_dirty_i,
  input  logic                          fill_shared_i,
  // snoop port
  input  logic                          lookup_req_i,
  input  logic [INDEX_W-1:0]            lookup_index_i,
  input  logic [TAG_W-1:0]              lookup_tag_i,
  output logic                          lookup_gnt_o,
  output logic [WAYS-1:0]               hit_way_o,
  output logic                          hit_dirty_o,
  output logic                          hit_shared_o,
  input  logic                          flag_we_i,
  input  logic [WAYS-1:0]               flag_way_i,
  input  snoop_pkg::line_state_u        flag_mask_i,
  input  snoop_pkg::line_state_u        flag_value_i
);
  import snoop_pkg::*;

  localparam int unsigned SETS = 1 << INDEX_W;

  logic [TAG_W-1:0]   tag_mem   [SETS][WAYS];
  line_state_u        state_mem [SETS][WAYS];
  logic [INDEX_W-1:0] fill_index;
  logic [TAG_W-1:0]   fill_tag;
  line_flags_t        fill_flags;
  logic [WAYS-1:0]    hit;
  logic [WAYS-1:0]    dirty_vec;
  logic [WAYS-1:0]    shared_vec;

  assign fill_index = fill_addr_i[OFFSET_W +: INDEX_W];
  assign fill_tag   = fill_addr_i[ADDR_W-1 -: TAG_W];

  assign fill_flags.valid  = 1'b1;
  assign fill_flags.dirty  = fill_dirty_i;
  assign fill_flags.shared = fill_shared_i;

  // fill has the arrays this cycle, snoop side waits
  assign lookup_gnt_o = (lookup_req_i || flag_we_i) && !fill_valid_i;

  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      hit[w]        = state_mem[lookup_index_i][w].flags.valid &&
                      (tag_mem[lookup_index_i][w] == lookup_tag_i);
      dirty_vec[w]  = state_mem[lookup_index_i][w].flags.dirty;
      shared_vec[w] = state_mem[lookup_index_i][w].flags.shared;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_valid_i) begin
      tag_mem[fill_index][fill_way_i] <= fill_tag;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < SETS; s++) begin
        for (int w = 0; w < WAYS; w++) begin
          state_mem[s][w] <= '0;
        end
      end
    end else if (fill_valid_i) begin
      state_mem[fill_index][fill_way_i].flags <= fill_flags;
    end else if (flag_we_i) begin
      // masked update, untouched flags keep their value
      for (int w = 0; w < WAYS; w++) begin
        if (flag_way_i[w]) begin
          state_mem[lookup_index_i][w].bits <=
            (state_mem[lookup_index_i][w].bits & ~flag_mask_i.bits) |
            (flag_value_i.bits & flag_mask_i.bits);
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hit_way_o    <= '0;
      hit_dirty_o  <= 1'b0;
      hit_shared_o <= 1'b0;
    end else if (lookup_req_i && lookup_gnt_o) begin
      hit_way_o    <= hit;
      hit_dirty_o  <= |(hit & dirty_vec);
      hit_shared_o <= |(hit & shared_vec);
    end
  end

endmodule

`default_nettype wire

//--- tb_snoop_cache.sv
`default_nettype none

module tb_snoop_cache;
  import snoop_pkg::*;

  localparam int unsigned WAYS    = 4;
  localparam int unsigned INDEX_W = 4;
  localparam int unsigned SETS    = 1 << INDEX_W;
  localparam int unsigned TAG_W   = ADDR_W - INDEX_W - OFFSET_W;
  localparam int          OP_FILL = 0;
  localparam int          OP_SNOOP = 1;
  localparam int          OP_BUSY = 2;

  logic              clk_i = 1'b0;
  logic              rst_ni;
  logic              bypass_i;
  logic              ac_valid_i;
  logic [ADDR_W-1:0] ac_addr_i;
  snoop_e            ac_snoop_i;
  logic              ac_ready_o;
  logic              cr_valid_o;
  cr_resp_t          cr_resp_o;
  logic              cr_ready_i;
  logic              cd_valid_o;
  logic [BEAT_W-1:0] cd_data_o;
  logic              cd_last_o;
  logic              cd_ready_i;
  logic              fill_valid_i;
  logic [ADDR_W-1:0] fill_addr_i;
  logic [1:0]        fill_way_i;
  logic [LINE_W-1:0] fill_data_i;
  logic              fill_dirty_i;
  logic              fill_shared_i;
  logic              busy_o;
  logic              invalidate_o;
  logic [ADDR_W-1:0] invalidate_addr_o;

  // reference model of the cache contents
  logic              m_valid  [SETS][WAYS];
  logic              m_dirty  [SETS][WAYS];
  logic              m_shared [SETS][WAYS];
  logic [TAG_W-1:0]  m_tag    [SETS][WAYS];
  logic [LINE_W-1:0] m_data   [SETS][WAYS];

  // test table
  string             t_name   [$];
  int                t_op     [$];
  logic [ADDR_W-1:0] t_addr   [$];
  int                t_way    [$];
  logic              t_dirty  [$];
  logic              t_shared [$];
  snoop_e            t_snoop  [$];
  logic              t_bypass [$];

  // captured by the monitor
  int                cr_count;
  logic [3:0]        resp_seen;
  logic [BEAT_W-1:0] beat_data [$];
  logic              beat_last [$];
  int                inv_count;
  logic [ADDR_W-1:0] inv_addr;
  logic              cr_hold;
  logic [3:0]        cr_hold_resp;
  logic              cd_hold;
  logic [BEAT_W-1:0] cd_hold_data;
  logic              cd_hold_last;

  string             cur_name;
  int                test_errs;
  int                total_errs;
  int                failed_tests;
  int                cycles = 0;
  int                limit = 0;

  snoop_cache_top #(
    .WAYS    (WAYS),
    .INDEX_W (INDEX_W)
  ) uut (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .bypass_i          (bypass_i),
    .ac_valid_i        (ac_valid_i),
    .ac_addr_i         (ac_addr_i),
    .ac_snoop_i        (ac_snoop_i),
    .ac_ready_o        (ac_ready_o),
    .cr_valid_o        (cr_valid_o),
    .cr_resp_o         (cr_resp_o),
    .cr_ready_i        (cr_ready_i),
    .cd_valid_o        (cd_valid_o),
    .cd_data_o         (cd_data_o),
    .cd_last_o         (cd_last_o),
    .cd_ready_i        (cd_ready_i),
    .fill_valid_i      (fill_valid_i),
    .fill_addr_i       (fill_addr_i),
    .fill_way_i        (fill_way_i),
    .fill_data_i       (fill_data_i),
    .fill_dirty_i      (fill_dirty_i),
    .fill_shared_i     (fill_shared_i),
    .busy_o            (busy_o),
    .invalidate_o      (invalidate_o),
    .invalidate_addr_o (invalidate_addr_o)
  );

  always #4 clk_i = ~clk_i;

  task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act) else begin
      $display("Mismatch %s %s: expected %h, actual %h", cur_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_true(input string what, input logic cond);
    assert (cond === 1'b1) else begin
      $display("Error in %s: %s", cur_name, what);
      test_errs++;
    end
  endtask

  // random back-pressure on both response channels
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      cr_ready_i = 1'b0;
      cd_ready_i = 1'b0;
    end else begin
      cr_ready_i = ($urandom % 4) != 0;
      cd_ready_i = ($urandom % 3) != 0;
    end
  end

  // handshakes as the DUT sees them at the clock edge
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (cr_hold) begin
        check_true("CR response dropped or changed while stalled",
                   cr_valid_o && (4'(cr_resp_o) == cr_hold_resp));
      end
      if (cd_hold) begin
        check_true("CD beat dropped or changed while stalled",
                   cd_valid_o && cd_data_o == cd_hold_data && cd_last_o == cd_hold_last);
      end
      if (cr_valid_o && cr_ready_i) begin
        cr_count++;
        resp_seen = cr_resp_o;
      end
      if (cd_valid_o && cd_ready_i) begin
        beat_data.push_back(cd_data_o);
        beat_last.push_back(cd_last_o);
      end
      if (invalidate_o) begin
        inv_count++;
        inv_addr = invalidate_addr_o;
      end
      cr_hold      = cr_valid_o && !cr_ready_i;
      cr_hold_resp = cr_resp_o;
      cd_hold      = cd_valid_o && !cd_ready_i;
      cd_hold_data = cd_data_o;
      cd_hold_last = cd_last_o;
    end else begin
      cr_hold = 1'b0;
      cd_hold = 1'b0;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (limit != 0 && cycles >= limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("Regression failed");
      $finish;
    end
  end

  task automatic add_entry(input string name, input int op, input logic [ADDR_W-1:0] addr,
                           input int way, input logic dirty, input logic shared,
                           input logic [3:0] snoop, input logic bypass);
    t_name.push_back(name);
    t_op.push_back(op);
    t_addr.push_back(addr);
    t_way.push_back(way);
    t_dirty.push_back(dirty);
    t_shared.push_back(shared);
    t_snoop.push_back(snoop_e'(snoop));
    t_bypass.push_back(bypass);
  endtask

  task automatic build_table();
    logic [ADDR_W-1:0] a;
    logic [ADDR_W-1:0] b;
    logic [ADDR_W-1:0] c;
    logic [ADDR_W-1:0] d;
    logic [ADDR_W-1:0] e;
    a = 32'h1234_5610;
    b = 32'h0abc_d020;
    c = 32'h0055_5530;
    d = 32'h7777_0040;
    // same set as b with another tag
    e = 32'h0abc_e020;
    add_entry("empty_ro", OP_SNOOP, a, 0, 0, 0, READ_ONCE, 0);
    add_entry("fill_a", OP_FILL, a, 0, 0, 0, 0, 0);
    add_entry("fill_b", OP_FILL, b, 1, 1, 0, 0, 0);
    add_entry("fill_e", OP_FILL, e, 2, 0, 1, 0, 0);
    add_entry("ro_clean", OP_SNOOP, a, 0, 0, 0, READ_ONCE, 0);
    add_entry("rs_clean", OP_SNOOP, a, 0, 0, 0, READ_SHARED, 0);
    add_entry("ro_after_rs", OP_SNOOP, a, 0, 0, 0, READ_ONCE, 0);
    add_entry("ro_shared_fill", OP_SNOOP, e, 0, 0, 0, READ_ONCE, 0);
    add_entry("ru_dirty", OP_SNOOP, b, 0, 0, 0, READ_UNIQUE, 0);
    add_entry("ro_after_ru", OP_SNOOP, b, 0, 0, 0, READ_ONCE, 0);
    add_entry("fill_c", OP_FILL, c, 3, 1, 0, 0, 0);
    add_entry("ci_dirty", OP_SNOOP, c, 0, 0, 0, CLEAN_INVALID, 0);
    add_entry("ro_after_ci", OP_SNOOP, c, 0, 0, 0, READ_ONCE, 0);
    add_entry("fill_d", OP_FILL, d, 0, 0, 0, 0, 0);
    add_entry("ci_clean", OP_SNOOP, d, 0, 0, 0, CLEAN_INVALID, 0);
    add_entry("ro_after_ci_clean", OP_SNOOP, d, 0, 0, 0, READ_ONCE, 0);
    add_entry("bad_type", OP_SNOOP, e, 0, 0, 0, 4'd3, 0);
    add_entry("bypass_ru", OP_SNOOP, e, 0, 0, 0, READ_UNIQUE, 1);
    add_entry("ro_unchanged", OP_SNOOP, e, 0, 0, 0, READ_ONCE, 0);
    add_entry("ru_clean_fills", OP_BUSY, e, 0, 0, 0, READ_UNIQUE, 0);
    add_entry("fill_b_again", OP_FILL, b, 3, 1, 1, 0, 0);
    add_entry("rs_dirty_fills", OP_BUSY, b, 0, 0, 0, READ_SHARED, 0);
    add_entry("ro_dirty", OP_SNOOP, b, 0, 0, 0, READ_ONCE, 0);
    add_entry("ci_dirty_fills", OP_BUSY, b, 0, 0, 0, CLEAN_INVALID, 0);
    add_entry("bad_type_miss", OP_SNOOP, c, 0, 0, 0, 4'd15, 0);
  endtask

  function automatic int find_way(input logic [ADDR_W-1:0] addr);
    int idx;
    int way;
    idx = int'(addr[OFFSET_W +: INDEX_W]);
    way = -1;
    for (int w = 0; w < WAYS; w++) begin
      if (m_valid[idx][w] && m_tag[idx][w] == addr[ADDR_W-1 -: TAG_W]) begin
        way = w;
      end
    end
    return way;
  endfunction

  // drives one fill cycle and installs the line in the model
  task automatic drive_fill(input logic [ADDR_W-1:0] addr, input int way, input logic dirty,
                            input logic shared);
    logic [LINE_W-1:0] data;
    int                idx;
    data = {$urandom, $urandom, $urandom, $urandom};
    idx  = int'(addr[OFFSET_W +: INDEX_W]);
    fill_valid_i  = 1'b1;
    fill_addr_i   = addr;
    fill_way_i    = 2'(way);
    fill_data_i   = data;
    fill_dirty_i  = dirty;
    fill_shared_i = shared;
    m_valid[idx][way]  = 1'b1;
    m_dirty[idx][way]  = dirty;
    m_shared[idx][way] = shared;
    m_tag[idx][way]    = addr[ADDR_W-1 -: TAG_W];
    m_data[idx][way]   = data;
  endtask

  task automatic run_snoop(input int i);
    logic [ADDR_W-1:0] addr;
    logic [LINE_W-1:0] exp_line;
    logic              dt;
    logic              pd;
    logic              sh;
    logic              err;
    int                way;
    int                idx;
    int                exp_inv;
    int                n;
    addr     = t_addr[i];
    idx      = int'(addr[OFFSET_W +: INDEX_W]);
    way      = find_way(addr);
    exp_line = (way >= 0) ? m_data[idx][way] : '0;
    dt       = 1'b0;
    pd       = 1'b0;
    sh       = 1'b0;
    err      = 1'b0;
    exp_inv  = 0;
    if (!t_bypass[i]) begin
      case (t_snoop[i])
        READ_ONCE: begin
          dt = (way >= 0);
          sh = (way >= 0) && m_shared[idx][way];
        end
        READ_SHARED: begin
          if (way >= 0) begin
            dt = 1'b1;
            sh = 1'b1;
            m_shared[idx][way] = 1'b1;
          end
        end
        READ_UNIQUE, CLEAN_INVALID: begin
          if (way >= 0) begin
            pd      = m_dirty[idx][way];
            dt      = (t_snoop[i] == READ_UNIQUE) || m_dirty[idx][way];
            exp_inv = 1;
            m_valid[idx][way]  = 1'b0;
            m_dirty[idx][way]  = 1'b0;
            m_shared[idx][way] = 1'b0;
          end
        end
        default: begin
          err = 1'b1;
        end
      endcase
    end

    @(negedge clk_i);
    cr_count  = 0;
    inv_count = 0;
    beat_data.delete();
    beat_last.delete();
    ac_valid_i = 1'b1;
    ac_addr_i  = addr;
    ac_snoop_i = t_snoop[i];
    bypass_i   = t_bypass[i];
    @(posedge clk_i);
    while (!ac_ready_o) @(posedge clk_i);
    @(negedge clk_i);
    ac_valid_i = 1'b0;
    // fills to set 15 compete with the snoop for the arrays
    n = 0;
    while (busy_o) begin
      if (t_op[i] == OP_BUSY && n < 3) begin
        drive_fill({24'($urandom), 8'hf0}, n, 1'b0, 1'b0);
      end else begin
        fill_valid_i = 1'b0;
      end
      n++;
      @(negedge clk_i);
    end
    fill_valid_i = 1'b0;
    bypass_i     = 1'b0;

    check_value("cr handshakes", 1, cr_count);
    check_value("cr response", {dt, pd, sh, err}, resp_seen);
    check_value("cd beats", dt ? 2 : 0, beat_data.size());
    if (dt && beat_data.size() == 2) begin
      check_value("cd beat 0", exp_line[BEAT_W-1:0], beat_data[0]);
      check_value("cd beat 1", exp_line[LINE_W-1 -: BEAT_W], beat_data[1]);
      check_value("cd last 0", 0, beat_last[0]);
      check_value("cd last 1", 1, beat_last[1]);
    end
    check_value("invalidate pulses", exp_inv, inv_count);
    if (exp_inv == 1 && inv_count == 1) begin
      check_value("invalidate address", {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}}, inv_addr);
    end
  endtask

  initial begin
    void'($urandom(32'hb96c));
    rst_ni        = 1'b0;
    bypass_i      = 1'b0;
    ac_valid_i    = 1'b0;
    ac_addr_i     = '0;
    ac_snoop_i    = READ_ONCE;
    cr_ready_i    = 1'b0;
    cd_ready_i    = 1'b0;
    fill_valid_i  = 1'b0;
    fill_addr_i   = '0;
    fill_way_i    = '0;
    fill_data_i   = '0;
    fill_dirty_i  = 1'b0;
    fill_shared_i = 1'b0;
    cr_hold       = 1'b0;
    cd_hold       = 1'b0;
    total_errs    = 0;
    failed_tests  = 0;
    for (int s = 0; s < SETS; s++) begin
      for (int w = 0; w < WAYS; w++) begin
        m_valid[s][w]  = 1'b0;
        m_dirty[s][w]  = 1'b0;
        m_shared[s][w] = 1'b0;
      end
    end
    build_table();
    limit = t_name.size() * 64;

    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    cur_name  = "reset_idle";
    test_errs = 0;
    check_value("ac_ready_o", 0, ac_ready_o);
    check_value("cr_valid_o", 0, cr_valid_o);
    check_value("cd_valid_o", 0, cd_valid_o);
    check_value("invalidate_o", 0, invalidate_o);
    check_value("busy_o", 0, busy_o);
    $display("test %s: %s", cur_name, (test_errs == 0) ? "ok" : "FAILED");
    total_errs += test_errs;
    failed_tests += (test_errs != 0);

    for (int i = 0; i < t_name.size(); i++) begin
      cur_name  = t_name[i];
      test_errs = 0;
      if (t_op[i] == OP_FILL) begin
        @(negedge clk_i);
        drive_fill(t_addr[i], t_way[i], t_dirty[i], t_shared[i]);
        @(negedge clk_i);
        fill_valid_i = 1'b0;
      end else begin
        run_snoop(i);
      end
      $display("test %s: %s", cur_name, (test_errs == 0) ? "ok" : "FAILED");
      total_errs += test_errs;
      failed_tests += (test_errs != 0);
    end

    $display("tests %0d, failing tests %0d, errors %0d",
             t_name.size() + 1, failed_tests, total_errs);
    if (failed_tests == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
